//--- tb.f
+incdir+verif
rtl/spr_pkg.sv
rtl/spr_ticktimer.sv
rtl/spr_pic.sv
rtl/spr_bus_bridge.sv
rtl/spr_timer_top.sv
verif/tb_spr_timer.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run, pass is decided by the pass message in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f tb.f \
  --top-module tb_spr_timer -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -qF "Simulation completed successfully" \
  && echo "RESULT: PASS" \
  || { echo "RESULT: FAIL"; exit 1; }

//--- verif/spr_model.svh
// Reference functions predicting SPR read-back, timer stop value and interrupt levels
`ifndef SPR_MODEL_SVH
`define SPR_MODEL_SVH

// Expected read-back after a write of data to addr
function automatic spr_pkg::spr_data_t expected_readback(spr_pkg::spr_addr_t addr,
                                                         spr_pkg::spr_data_t data);
  logic [4:0] grp;
  grp = addr[15:spr_pkg::SPR_REG_W];
  if (grp == spr_pkg::SPR_GROUP_TT) begin
    return data;
  end
  // PIC registers are PIC_LINES wide
  if (grp == spr_pkg::SPR_GROUP_PIC) begin
    return data & spr_pkg::spr_data_t'({spr_pkg::PIC_LINES{1'b1}});
  end
  return '0;
endfunction

// TTCR parks at the period in stop mode
function automatic spr_pkg::spr_data_t stop_count(spr_pkg::spr_data_t period);
  return period & spr_pkg::spr_data_t'({spr_pkg::TT_PERIOD_W{1'b1}});
endfunction

// IP sets once an enabled and running timer has reached the period
function automatic logic tick_pending(spr_pkg::tt_mode_e mode, logic ie,
                                      int unsigned cycles, int unsigned period);
  return ie && (mode != spr_pkg::TT_DISABLED) && (cycles >= period);
endfunction

// PICSR keeps every line seen since the last write
function automatic logic [spr_pkg::PIC_LINES-1:0] sticky_status(
    logic [spr_pkg::PIC_LINES-1:0] prev, logic [spr_pkg::PIC_LINES-1:0] pattern);
  return prev | pattern;
endfunction

// External interrupt from status and mask
function automatic logic masked_irq(logic [spr_pkg::PIC_LINES-1:0] status,
                                    logic [spr_pkg::PIC_LINES-1:0] mask);
  return |(status & mask);
endfunction

`endif

//--- verif/tb_spr_timer.sv
// Testbench for the SPR timer block covering bus handshake, tick timer modes and PIC lines
`timescale 1ns/10ps
`default_nettype none

module tb_spr_timer;

  import spr_pkg::*;

  `include "spr_model.svh"

  ////////////////////////////////////////////////////////////
  // Constants, clock and DUT
  ////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD     = 10;
  localparam int HS_TIMEOUT     = 20;
  // Edges from req rise to ack rise
  localparam int ACK_LATENCY    = 2;
  // Edges from req fall to ack fall
  localparam int ACK_RELEASE    = 1;
  localparam int unsigned STOP_PERIOD    = 20;
  localparam int unsigned RESTART_PERIOD = 15;
  localparam int RESTART_READS  = 6;
  // Rough cycle budget per test
  localparam int TEST1_CYCLES   = 300;
  localparam int TEST2_CYCLES   = STOP_PERIOD + 60;
  localparam int TEST3_CYCLES   = 40;
  localparam int TEST4_CYCLES   = RESTART_READS * 25 + 50;
  localparam int TEST5_CYCLES   = 100;
  localparam int MARGIN_CYCLES  = 200;
  localparam int WATCHDOG_NS    = (TEST1_CYCLES + TEST2_CYCLES + TEST3_CYCLES +
                                   TEST4_CYCLES + TEST5_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 req_i;
  logic                 we_i;
  spr_addr_t            addr_i;
  spr_data_t            wdata_i;
  logic [PIC_LINES-1:0] irq_i;
  logic                 ack_o;
  spr_data_t            rdata_o;
  logic                 tick_irq_o;
  logic                 ext_irq_o;

  integer      seed = 32;
  int          errors = 0;
  int          test_base = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int unsigned cycle_cnt = 0;

  spr_data_t            rnd;
  spr_data_t            rd_data;
  spr_data_t            ttmr_val;
  spr_data_t            ttcr_val;
  spr_data_t            picmr_val;
  logic [PIC_LINES-1:0] pattern;
  logic [PIC_LINES-1:0] mask;
  logic [PIC_LINES-1:0] status;
  int                   gap;
  int unsigned          start_cycle;
  int unsigned          elapsed;

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Free-running cycle count for the timer model
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  spr_timer_top DUT (
    .clk        (clk),
    .rst        (rst),
    .req_i      (req_i),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .irq_i      (irq_i),
    .ack_o      (ack_o),
    .rdata_o    (rdata_o),
    .tick_irq_o (tick_irq_o),
    .ext_irq_o  (ext_irq_o)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic spr_addr_t spr_address(logic [4:0] grp, logic [SPR_REG_W-1:0] regn);
    return {grp, regn};
  endfunction

  // TTMR word from mode, enable and period
  function automatic spr_data_t ttmr_word(tt_mode_e mode, logic ie, int unsigned period);
    spr_data_t w;
    w = '0;
    w[TTMR_MODE_HI:TTMR_MODE_LO] = mode;
    w[TTMR_IE_BIT] = ie;
    w[TT_PERIOD_W-1:0] = period[TT_PERIOD_W-1:0];
    return w;
  endfunction

  task automatic check_data(input string name, input spr_data_t exp, input spr_data_t act);
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // Full four-phase transfer sampled on the falling edge
  task automatic bus_transfer(input logic wr, input spr_addr_t addr, input spr_data_t data,
                              output spr_data_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    req_i   <= 1'b1;
    we_i    <= wr;
    addr_i  <= addr;
    wdata_i <= data;
    @(negedge clk);
    while (!ack_o && (waited < HS_TIMEOUT)) begin
      @(negedge clk);
      waited++;
    end
    if (!ack_o) begin
      $display("Handshake timed out waiting for ack to rise at %0t", $time);
      errors++;
    end else if (waited != ACK_LATENCY) begin
      $display("ERROR at %0t: ack_o rise latency expected %0d, got %0d",
               $time, ACK_LATENCY, waited);
      errors++;
    end
    rdata = rdata_o;
    @(posedge clk);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (ack_o && (waited < HS_TIMEOUT)) begin
      @(negedge clk);
      waited++;
    end
    if (ack_o) begin
      $display("Handshake timed out waiting for ack to fall at %0t", $time);
      errors++;
    end else if (waited != ACK_RELEASE) begin
      $display("ERROR at %0t: ack_o release latency expected %0d, got %0d",
               $time, ACK_RELEASE, waited);
      errors++;
    end
  endtask

  task automatic spr_write(input spr_addr_t addr, input spr_data_t data);
    spr_data_t unused;
    bus_transfer(1'b1, addr, data, unused);
  endtask

  task automatic spr_read(input spr_addr_t addr, output spr_data_t data);
    bus_transfer(1'b0, addr, '0, data);
  endtask

  // Let n edges pass and then sample mid-cycle
  task automatic settle(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic begin_test();
    test_base = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_base) begin
      $display("Test %s: PASS", name);
      tests_passed++;
    end else begin
      $display("Test %s: FAIL with %0d errors", name, errors - test_base);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////

  initial begin
    rst     <= 1'b1;
    req_i   <= 1'b0;
    we_i    <= 1'b0;
    addr_i  <= '0;
    wdata_i <= '0;
    irq_i   <= '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Read-back with the timer frozen
    begin_test();
    for (int i = 0; i < 4; i++) begin
      ttmr_val = $random(seed);
      ttmr_val[TTMR_MODE_HI:TTMR_MODE_LO] = TT_DISABLED;
      spr_write(spr_address(SPR_GROUP_TT, SPR_TTMR_REG), ttmr_val);
      spr_read(spr_address(SPR_GROUP_TT, SPR_TTMR_REG), rd_data);
      check_data("ttmr",
                 expected_readback(spr_address(SPR_GROUP_TT, SPR_TTMR_REG), ttmr_val),
                 rd_data);
      ttcr_val = $random(seed);
      spr_write(spr_address(SPR_GROUP_TT, SPR_TTCR_REG), ttcr_val);
      spr_read(spr_address(SPR_GROUP_TT, SPR_TTCR_REG), rd_data);
      check_data("ttcr",
                 expected_readback(spr_address(SPR_GROUP_TT, SPR_TTCR_REG), ttcr_val),
                 rd_data);
      picmr_val = $random(seed);
      spr_write(spr_address(SPR_GROUP_PIC, SPR_PICMR_REG), picmr_val);
      spr_read(spr_address(SPR_GROUP_PIC, SPR_PICMR_REG), rd_data);
      check_data("picmr",
                 expected_readback(spr_address(SPR_GROUP_PIC, SPR_PICMR_REG), picmr_val),
                 rd_data);
      // Unknown group reads zero and leaves the others alone
      rnd = $random(seed);
      spr_write(spr_address(5'd3, SPR_TTMR_REG), rnd);
      spr_read(spr_address(5'd3, SPR_TTMR_REG), rd_data);
      check_data("unknown_group",
                 expected_readback(spr_address(5'd3, SPR_TTMR_REG), rnd), rd_data);
      spr_read(spr_address(SPR_GROUP_TT, SPR_TTMR_REG), rd_data);
      check_data("ttmr_after_unknown", ttmr_val, rd_data);
      spr_read(spr_address(SPR_GROUP_TT, SPR_TTCR_REG), rd_data);
      check_data("ttcr_after_unknown", ttcr_val, rd_data);
      spr_read(spr_address(SPR_GROUP_PIC, SPR_PICMR_REG), rd_data);
      check_data("picmr_after_unknown",
                 expected_readback(spr_address(SPR_GROUP_PIC, SPR_PICMR_REG), picmr_val),
                 rd_data);
    end
    end_test("readback");

    // Stop mode parks at the period with IP set
    begin_test();
    spr_write(spr_address(SPR_GROUP_TT, SPR_TTMR_REG), ttmr_word(TT_STOP, 1'b1, STOP_PERIOD));
    spr_write(spr_address(SPR_GROUP_TT, SPR_TTCR_REG), '0);
    start_cycle = cycle_cnt;
    repeat (STOP_PERIOD + 12) @(posedge clk);
    spr_read(spr_address(SPR_GROUP_TT, SPR_TTCR_REG), rd_data);
    check_data("ttcr_stop", stop_count(spr_data_t'(STOP_PERIOD)), rd_data);
    elapsed = cycle_cnt - start_cycle;
    ttmr_val = ttmr_word(TT_STOP, 1'b1, STOP_PERIOD);
    ttmr_val[TTMR_IP_BIT] = tick_pending(TT_STOP, 1'b1, elapsed, STOP_PERIOD);
    spr_read(spr_address(SPR_GROUP_TT, SPR_TTMR_REG), rd_data);
    check_data("ttmr_stop", ttmr_val, rd_data);
    settle(0);
    check_bit("tick_irq_o", ttmr_val[TTMR_IP_BIT], tick_irq_o);
    end_test("stop_mode");

    // IP cleared by rewriting TTMR
    begin_test();
    spr_write(spr_address(SPR_GROUP_TT, SPR_TTMR_REG), ttmr_word(TT_DISABLED, 1'b0, 0));
    settle(3);
    check_bit("tick_irq_o", tick_pending(TT_DISABLED, 1'b0, 0, 0), tick_irq_o);
    spr_read(spr_address(SPR_GROUP_TT, SPR_TTMR_REG), rd_data);
    check_data("ttmr_clear", ttmr_word(TT_DISABLED, 1'b0, 0), rd_data);
    end_test("ip_clear");

    // Restart mode never passes the period
    begin_test();
    spr_write(spr_address(SPR_GROUP_TT, SPR_TTMR_REG),
              ttmr_word(TT_RESTART, 1'b1, RESTART_PERIOD));
    spr_write(spr_address(SPR_GROUP_TT, SPR_TTCR_REG), '0);
    start_cycle = cycle_cnt;
    for (int i = 0; i < RESTART_READS; i++) begin
      rnd = $random(seed);
      gap = int'(rnd[3:0]) + 1;
      repeat (gap) @(posedge clk);
      spr_read(spr_address(SPR_GROUP_TT, SPR_TTCR_REG), rd_data);
      if (rd_data > RESTART_PERIOD) begin
        $display("ERROR at %0t: ttcr_restart read %0d, above the period %0d",
                 $time, rd_data, RESTART_PERIOD);
        errors++;
      end
    end
    elapsed = cycle_cnt - start_cycle;
    ttmr_val = ttmr_word(TT_RESTART, 1'b1, RESTART_PERIOD);
    ttmr_val[TTMR_IP_BIT] = tick_pending(TT_RESTART, 1'b1, elapsed, RESTART_PERIOD);
    spr_read(spr_address(SPR_GROUP_TT, SPR_TTMR_REG), rd_data);
    check_data("ttmr_restart", ttmr_val, rd_data);
    settle(0);
    check_bit("tick_irq_o", ttmr_val[TTMR_IP_BIT], tick_irq_o);
    spr_write(spr_address(SPR_GROUP_TT, SPR_TTMR_REG), ttmr_word(TT_DISABLED, 1'b0, 0));
    end_test("restart_mode");

    // PIC status capture and masking
    begin_test();
    spr_write(spr_address(SPR_GROUP_PIC, SPR_PICMR_REG), '0);
    spr_write(spr_address(SPR_GROUP_PIC, SPR_PICSR_REG), '0);
    rnd = $random(seed);
    pattern = rnd[PIC_LINES-1:0];
    if (pattern == '0) begin
      pattern = 1;
    end
    @(posedge clk);
    irq_i <= pattern;
    repeat (2) @(posedge clk);
    status = sticky_status('0, pattern);
    spr_read(spr_address(SPR_GROUP_PIC, SPR_PICSR_REG), rd_data);
    check_data("picsr", spr_data_t'(status), rd_data);
    settle(2);
    check_bit("ext_irq_o", masked_irq(status, '0), ext_irq_o);
    rnd = $random(seed);
    mask = rnd[PIC_LINES-1:0];
    if (mask == '0) begin
      mask = 1;
    end
    spr_write(spr_address(SPR_GROUP_PIC, SPR_PICMR_REG), spr_data_t'(mask));
    settle(2);
    check_bit("ext_irq_o", masked_irq(status, mask), ext_irq_o);
    // Mask equal to the pattern makes the line show
    spr_write(spr_address(SPR_GROUP_PIC, SPR_PICMR_REG), spr_data_t'(pattern));
    settle(2);
    check_bit("ext_irq_o", masked_irq(status, pattern), ext_irq_o);
    @(posedge clk);
    irq_i <= '0;
    end_test("pic");

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog budget from the test lengths
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests ended at %0t", $time);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/spr_timer_top.sv
// Timer and interrupt SPR block with bus bridge, tick timer and PIC
`timescale 1ns/10ps
`default_nettype none

module spr_timer_top (
  input  wire                          clk,
  input  wire                          rst,
  // Four-phase SPR port
  input  wire                          req_i,
  input  wire                          we_i,
  input  wire spr_pkg::spr_addr_t      addr_i,
  input  wire spr_pkg::spr_data_t      wdata_i,
  // External interrupt lines
  input  wire [spr_pkg::PIC_LINES-1:0] irq_i,
  output logic                         ack_o,
  output spr_pkg::spr_data_t           rdata_o,
  output logic                         tick_irq_o,
  output logic                         ext_irq_o
);

  import spr_pkg::*;

  // Bridge to unit wires
  logic                 access_tt;
  logic                 access_pic;
  logic                 we;
  logic [SPR_REG_W-1:0] reg_addr;
  spr_data_t            wdata;
  spr_data_t            tt_rdata;
  spr_data_t            pic_rdata;

  spr_bus_bridge u_bridge (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .tt_rdata_i   (tt_rdata),
    .pic_rdata_i  (pic_rdata),
    .access_tt_o  (access_tt),
    .access_pic_o (access_pic),
    .we_o         (we),
    .reg_addr_o   (reg_addr),
    .wdata_o      (wdata),
    .ack_o        (ack_o),
    .rdata_o      (rdata_o)
  );

  spr_ticktimer u_ticktimer (
    .clk        (clk),
    .rst        (rst),
    .access_i   (access_tt),
    .we_i       (we),
    .reg_addr_i (reg_addr),
    .wdata_i    (wdata),
    .rdata_o    (tt_rdata),
    .tick_irq_o (tick_irq_o)
  );

  spr_pic u_pic (
    .clk        (clk),
    .rst        (rst),
    .access_i   (access_pic),
    .we_i       (we),
    .reg_addr_i (reg_addr),
    .wdata_i    (wdata),
    .irq_i      (irq_i),
    .rdata_o    (pic_rdata),
    .ext_irq_o  (ext_irq_o)
  );

endmodule

`default_nettype wire

//--- rtl/spr_bus_bridge.sv
// Four-phase req/ack SPR slave that decodes the group and merges unit replies
`timescale 1ns/10ps
`default_nettype none

module spr_bus_bridge (
  input  wire                           clk,
  input  wire                           rst,
  // Master side
  input  wire                           req_i,
  input  wire                           we_i,
  input  wire spr_pkg::spr_addr_t       addr_i,
  input  wire spr_pkg::spr_data_t       wdata_i,
  // Unit replies are zero when not strobed
  input  wire spr_pkg::spr_data_t       tt_rdata_i,
  input  wire spr_pkg::spr_data_t       pic_rdata_i,
  // Unit side
  output logic                          access_tt_o,
  output logic                          access_pic_o,
  output logic                          we_o,
  output logic [spr_pkg::SPR_REG_W-1:0] reg_addr_o,
  output spr_pkg::spr_data_t            wdata_o,
  // Reply to master
  output logic                          ack_o,
  output spr_pkg::spr_data_t            rdata_o
);

  import spr_pkg::*;

  bridge_state_e state;
  spr_addr_t     addr_q;
  spr_data_t     wdata_q;
  logic          we_q;
  logic [4:0]    group;

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= BR_IDLE;
      addr_q  <= '0;
      wdata_q <= '0;
      we_q    <= 1'b0;
      rdata_o <= '0;
    end else begin
      case (state)
        BR_IDLE: begin
          // Capture the request held by the master until ack
          if (req_i) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            we_q    <= we_i;
            state   <= BR_XFER;
          end
        end
        BR_XFER: begin
          // At most one reply is nonzero in the strobe cycle
          rdata_o <= tt_rdata_i | pic_rdata_i;
          state   <= BR_ACK;
        end
        BR_ACK: begin
          // Hold ack and data until req drops
          if (!req_i) begin
            state <= BR_IDLE;
          end
        end
        default: begin
          state <= BR_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Group decode and unit strobes
  ////////////////////////////////////////////////////////////

  assign group = addr_q[$bits(spr_addr_t)-1:SPR_REG_W];

  // Unknown groups get no strobe
  assign access_tt_o  = (state == BR_XFER) && (group == SPR_GROUP_TT);
  assign access_pic_o = (state == BR_XFER) && (group == SPR_GROUP_PIC);

  assign we_o       = we_q;
  assign reg_addr_o = addr_q[SPR_REG_W-1:0];
  assign wdata_o    = wdata_q;

  // Decoded from the state register
  assign ack_o = (state == BR_ACK);

endmodule

`default_nettype wire

//--- rtl/spr_pic.sv
// Programmable interrupt controller with PICMR mask and sticky PICSR status
`timescale 1ns/10ps
`default_nettype none

module spr_pic (
  input  wire                           clk,
  input  wire                           rst,
  // Strobed access from the bridge
  input  wire                           access_i,
  input  wire                           we_i,
  input  wire [spr_pkg::SPR_REG_W-1:0]  reg_addr_i,
  input  wire spr_pkg::spr_data_t       wdata_i,
  // External interrupt lines
  input  wire [spr_pkg::PIC_LINES-1:0]  irq_i,
  output spr_pkg::spr_data_t            rdata_o,
  output logic                          ext_irq_o
);

  import spr_pkg::*;

  logic [PIC_LINES-1:0] picmr;
  logic [PIC_LINES-1:0] picsr;
  logic                 picmr_sel;
  logic                 picsr_sel;

  assign picmr_sel = access_i && (reg_addr_i == SPR_PICMR_REG);
  assign picsr_sel = access_i && (reg_addr_i == SPR_PICSR_REG);

  // Mask register
  always_ff @(posedge clk) begin
    if (rst) begin
      picmr <= '0;
    end else if (picmr_sel && we_i) begin
      picmr <= wdata_i[PIC_LINES-1:0];
    end
  end

  // Status where lines still high come back at once
  always_ff @(posedge clk) begin
    if (rst) begin
      picsr <= '0;
    end else if (picsr_sel && we_i) begin
      picsr <= wdata_i[PIC_LINES-1:0] | irq_i;
    end else begin
      picsr <= picsr | irq_i;
    end
  end

  // Any unmasked pending line
  always_ff @(posedge clk) begin
    if (rst) begin
      ext_irq_o <= 1'b0;
    end else begin
      ext_irq_o <= |(picsr & picmr);
    end
  end

  // Zero-extended read-back and zero when not selected
  always_comb begin
    rdata_o = '0;
    if (picmr_sel) begin
      rdata_o[PIC_LINES-1:0] = picmr;
    end else if (picsr_sel) begin
      rdata_o[PIC_LINES-1:0] = picsr;
    end
  end

endmodule

`default_nettype wire

//--- rtl/spr_ticktimer.sv
// Tick timer holding TTMR and TTCR with four count modes and a match interrupt
`timescale 1ns/10ps
`default_nettype none

module spr_ticktimer (
  input  wire                          clk,
  input  wire                          rst,
  // Strobed access from the bridge
  input  wire                          access_i,
  input  wire                          we_i,
  input  wire [spr_pkg::SPR_REG_W-1:0] reg_addr_i,
  input  wire spr_pkg::spr_data_t      wdata_i,
  output spr_pkg::spr_data_t           rdata_o,
  // Level interrupt following TTMR.IP
  output logic                         tick_irq_o
);

  import spr_pkg::*;

  spr_data_t ttmr;
  spr_data_t ttcr;
  tt_mode_e  mode;
  logic      ttmr_sel;
  logic      ttcr_sel;
  logic      match;
  logic      cnt_clear;
  logic      cnt_run;

  // Register select only while the strobe is up
  assign ttmr_sel = access_i && (reg_addr_i == SPR_TTMR_REG);
  assign ttcr_sel = access_i && (reg_addr_i == SPR_TTCR_REG);

  assign mode  = tt_mode_e'(ttmr[TTMR_MODE_HI:TTMR_MODE_LO]);
  // Period compare on the low bits only
  assign match = (ttcr[TT_PERIOD_W-1:0] == ttmr[TT_PERIOD_W-1:0]);

  ////////////////////////////////////////////////////////////
  // Mode control
  ////////////////////////////////////////////////////////////

  // Restart mode wraps to zero on match
  assign cnt_clear = (mode == TT_RESTART) && match;
  // Stop and restart count up to the match and continuous counts always
  assign cnt_run = (((mode == TT_RESTART) || (mode == TT_STOP)) && !match) ||
                   (mode == TT_CONTINUOUS);

  // TTMR write wins over the pending update
  always_ff @(posedge clk) begin
    if (rst) begin
      ttmr <= '0;
    end else if (ttmr_sel && we_i) begin
      // Software clears IP by rewriting it as zero
      ttmr <= wdata_i;
    end else if (match && ttmr[TTMR_IE_BIT] && (mode != TT_DISABLED)) begin
      ttmr[TTMR_IP_BIT] <= 1'b1;
    end
  end

  // TTCR write wins over counting
  always_ff @(posedge clk) begin
    if (rst) begin
      ttcr <= '0;
    end else if (ttcr_sel && we_i) begin
      ttcr <= wdata_i;
    end else if (cnt_clear) begin
      ttcr <= '0;
    end else if (cnt_run) begin
      ttcr <= ttcr + 32'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  // Zero unless selected so the bridge can OR the replies
  always_comb begin
    rdata_o = '0;
    if (ttmr_sel) begin
      rdata_o = ttmr;
    end else if (ttcr_sel) begin
      rdata_o = ttcr;
    end
  end

  assign tick_irq_o = ttmr[TTMR_IP_BIT];

endmodule

`default_nettype wire

//--- rtl/spr_pkg.sv
// SPR address map, TTMR fields and enums shared by the timer block
`default_nettype none

package spr_pkg;

  ////////////////////////////////////////////////////////////
  // Address and data words
  ////////////////////////////////////////////////////////////

  // Group in bits 15..11 and register in bits 10..0
  typedef logic [15:0] spr_addr_t;
  typedef logic [31:0] spr_data_t;

  // Register offset width inside a group
  localparam int SPR_REG_W = 11;

  // Group numbers
  localparam logic [4:0] SPR_GROUP_PIC = 5'd9;
  localparam logic [4:0] SPR_GROUP_TT  = 5'd10;

  // Tick timer registers
  localparam logic [SPR_REG_W-1:0] SPR_TTMR_REG = 11'd0;
  localparam logic [SPR_REG_W-1:0] SPR_TTCR_REG = 11'd1;

  // PIC registers
  localparam logic [SPR_REG_W-1:0] SPR_PICMR_REG = 11'd0;
  localparam logic [SPR_REG_W-1:0] SPR_PICSR_REG = 11'd2;

  ////////////////////////////////////////////////////////////
  // TTMR fields
  ////////////////////////////////////////////////////////////

  localparam int TTMR_MODE_HI = 31;
  localparam int TTMR_MODE_LO = 30;
  localparam int TTMR_IE_BIT  = 29;
  localparam int TTMR_IP_BIT  = 28;
  // Match compare covers the period field only
  localparam int TT_PERIOD_W  = 28;

  // External interrupt lines into the PIC
  localparam int PIC_LINES = 16;

  typedef enum logic [1:0] {
    TT_DISABLED   = 2'b00,
    TT_RESTART    = 2'b01,
    TT_STOP       = 2'b10,
    TT_CONTINUOUS = 2'b11
  } tt_mode_e;

  typedef enum logic [1:0] {
    BR_IDLE = 2'b00,
    BR_XFER = 2'b01,
    BR_ACK  = 2'b10
  } bridge_state_e;

endpackage

`default_nettype wire
